//--- src.f
link_pkg.sv
wb_arbiter.sv
link_regs.sv
tx_credit_tracker.sv
link_ctrl_top.sv
tb_clkgen.sv
link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the link control testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module link_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vlink_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "sim failed" sim.log; then
   exit 1
fi
exit 0

//--- link_tb.sv
//##########################################################################
// link control testbench with bus tasks, xorshift stimulus, assertions,
// per test reporting and a cycle timeout
//##########################################################################
`timescale 1ns/100ps

module link_tb;
   import link_pkg::*;

   // longest run is a few hundred cycles, so 4000 leaves wide margin
   localparam int max_cycles = 4000;

   logic               clk;
   logic               nreset;
   wb_req_t            m0_req;
   wb_req_t            m1_req;
   wb_rsp_t            m0_rsp;
   wb_rsp_t            m1_rsp;
   logic               devicemode;
   logic               deviceready;
   logic               phy_linkactive;
   logic               tx_pkt_req;
   logic               tx_pkt_resp;
   logic               rx_crdt_req;
   logic               rx_crdt_resp;
   logic               host_linkactive;
   logic [1:0]         csr_arbmode;
   logic               csr_txen;
   logic               csr_rxen;
   iowidth_t           csr_txiowidth;
   iowidth_t           csr_rxiowidth;
   logic               crdt_update;

   int                 cycle = 0;
   int                 errors = 0;
   int                 tests = 0;
   int                 failed = 0;
   int                 test_start_errs;
   string              test_name;
   int                 last_lat;          // ack latency of the last access
   int                 ack_cnt0 = 0;
   int                 ack_cnt1 = 0;
   int                 ack_order[$];      // port of each ack, in order
   logic [31:0]        seed;
   reg_data_t          model [0:7];       // expected contents per word
   crdt_t              req_model;
   crdt_t              resp_model;

   tb_clkgen u_tb_clkgen (.clk(clk));

   link_ctrl_top u_link_ctrl_top (
      .clk             (clk),
      .nreset          (nreset),
      .m0_req          (m0_req),
      .m1_req          (m1_req),
      .m0_rsp          (m0_rsp),
      .m1_rsp          (m1_rsp),
      .devicemode      (devicemode),
      .deviceready     (deviceready),
      .phy_linkactive  (phy_linkactive),
      .tx_pkt_req      (tx_pkt_req),
      .tx_pkt_resp     (tx_pkt_resp),
      .rx_crdt_req     (rx_crdt_req),
      .rx_crdt_resp    (rx_crdt_resp),
      .host_linkactive (host_linkactive),
      .csr_arbmode     (csr_arbmode),
      .csr_txen        (csr_txen),
      .csr_rxen        (csr_rxen),
      .csr_txiowidth   (csr_txiowidth),
      .csr_rxiowidth   (csr_rxiowidth),
      .crdt_update     (crdt_update)
   );

   //########################################################################
   // cycle count, ack counters, timeout and bus assertions
   //########################################################################
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (m0_rsp.ack)
         ack_cnt0 <= ack_cnt0 + 1;
      if (m1_rsp.ack)
         ack_cnt1 <= ack_cnt1 + 1;
   end

   initial begin : watchdog
      wait (cycle >= max_cycles);
      $display("timeout after %0d cycles, a bus access or pulse never arrived", cycle);
      $display("sim failed");
      $finish;
   end

   a_one_owner: assert property (@(posedge clk) disable iff (!nreset)
                                 !(m0_rsp.ack && m1_rsp.ack))
      else begin
         $display("both masters acked in one cycle at %0t", $time);
         errors++;
      end

   a_m0_pulse: assert property (@(posedge clk) disable iff (!nreset)
                                m0_rsp.ack |=> !m0_rsp.ack)
      else begin
         $display("m0 ack longer than one cycle at %0t", $time);
         errors++;
      end

   a_m1_pulse: assert property (@(posedge clk) disable iff (!nreset)
                                m1_rsp.ack |=> !m1_rsp.ack)
      else begin
         $display("m1 ack longer than one cycle at %0t", $time);
         errors++;
      end

   //########################################################################
   // helpers
   //########################################################################
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic reg_data_t rand_word();
      seed = xorshift32(seed);
      return seed;
   endfunction

   function automatic reg_addr_t adr_of(input int w);
      return {w[5:0], 2'b00};
   endfunction

   // writable words ctrl, txmode, rxmode, crdtinit, crdtintrvl
   function automatic int rw_word(input int i);
      case (i)
         0:       return 0;
         1:       return 2;
         2:       return 3;
         3:       return 4;
         default: return 5;
      endcase
   endfunction

   // credit count clamped to the 16 bit range
   function automatic crdt_t sat_step(input crdt_t cnt, input logic sent, input logic back);
      int v;
      v = int'(cnt) + int'(back) - int'(sent);
      if (v < 0)
         v = 0;
      if (v > 65535)
         v = 65535;
      return v[15:0];
   endfunction

   task automatic check_val(input string name, input reg_data_t exp, input reg_data_t act);
      assert (act === exp)
         else begin
            $display("ERR %0t %s exp %h got %h", $time, name, exp, act);
            errors++;
         end
   endtask

   task automatic settle(input int n);
      repeat (n) @(posedge clk);
      @(negedge clk);                      // sample mid cycle
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      test_start_errs = errors;
   endtask

   task automatic end_test();
      tests++;
      if (errors == test_start_errs)
         $display("test %0d %s: ok", tests, test_name);
      else begin
         failed++;
         $display("test %0d %s: %0d errors", tests, test_name, errors - test_start_errs);
      end
   endtask

   //########################################################################
   // wishbone classic master, holds the request until ack
   //########################################################################
   task automatic wb_access(input int port, input logic we, input reg_addr_t adr,
                            input reg_data_t wdat, output reg_data_t rdat);
      wb_req_t req;
      int      t0;
      logic    got;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = adr;
      req.dat = wdat;
      got     = 1'b0;
      rdat    = '0;
      @(posedge clk);
      if (port == 0)
         m0_req <= req;
      else
         m1_req <= req;
      t0 = cycle;                          // edge count before this one
      while (!got) begin
         @(negedge clk);
         if (port == 0 && m0_rsp.ack) begin
            got  = 1'b1;
            rdat = m0_rsp.dat;
         end else if (port == 1 && m1_rsp.ack) begin
            got  = 1'b1;
            rdat = m1_rsp.dat;
         end
      end
      ack_order.push_back(port);
      last_lat = cycle - t0 - 1;           // edges from stb to ack
      @(posedge clk);
      if (port == 0)
         m0_req <= '0;
      else
         m1_req <= '0;
   endtask

   task automatic wb_write(input int port, input reg_addr_t adr, input reg_data_t dat);
      reg_data_t unused;
      wb_access(port, 1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input int port, input reg_addr_t adr, output reg_data_t dat);
      wb_access(port, 1'b0, adr, '0, dat);
   endtask

   //########################################################################
   // tests
   //########################################################################
   task automatic test_reset();
      reg_data_t d;
      begin_test("reset values");
      check_val("host_linkactive", 32'h0, 32'(host_linkactive));
      check_val("csr_txen", 32'h0, 32'(csr_txen));
      check_val("csr_rxen", 32'h0, 32'(csr_rxen));
      check_val("crdt_update", 32'h0, 32'(crdt_update));
      check_val("m0_rsp.ack", 32'h0, 32'(m0_rsp.ack));
      check_val("m1_rsp.ack", 32'h0, 32'(m1_rsp.ack));
      model[0] = '0;
      model[1] = '0;                                    // link down
      model[2] = (32'(init_iowidth) << 16) | 32'h1;     // enable, width
      model[3] = model[2];
      model[4] = {crdt_depth, crdt_depth};
      model[5] = {16'h0000, intrvl_reset};
      model[6] = {crdt_depth, crdt_depth};              // counts follow init
      model[7] = '0;
      for (int w = 0; w < 8; w++) begin
         wb_read(0, adr_of(w), d);
         check_val($sformatf("m0_rsp.dat @%02h", adr_of(w)), model[w], d);
         assert (last_lat == 2)
            else begin
               $display("ERR %0t m0_rsp.ack latency exp 2 got %0d", $time, last_lat);
               errors++;
            end
      end
      end_test();
   endtask

   task automatic test_readback();
      reg_data_t d;
      int        w;
      begin_test("write and readback");
      for (int i = 0; i < 5; i++) begin
         w = rw_word(i);
         d = rand_word();
         wb_write(1, adr_of(w), d);
         model[w] = (w == 5) ? (d & 32'h0000ffff) : d;  // interval is 16 bits
      end
      wb_write(1, reg_status, rand_word());             // read only
      wb_write(1, 8'h1c, rand_word());                  // holes
      wb_write(1, 8'h40, rand_word());
      for (int i = 0; i < 8; i++) begin
         if (i != 6) begin                             // live counts skipped
            wb_read(0, adr_of(i), d);
            check_val($sformatf("m0_rsp.dat @%02h", adr_of(i)), model[i], d);
         end
      end
      wb_read(0, 8'h40, d);
      check_val("m0_rsp.dat @40", 32'h0, d);
      settle(0);
      check_val("csr_arbmode", 32'(model[0][5:4]), 32'(csr_arbmode));
      check_val("csr_txiowidth", 32'(model[2][23:16]), 32'(csr_txiowidth));
      check_val("csr_rxiowidth", 32'(model[3][23:16]), 32'(csr_rxiowidth));
      end_test();
   endtask

   task automatic check_link(input logic la);
      reg_data_t d;
      check_val("host_linkactive", 32'(la), 32'(host_linkactive));
      check_val("csr_txen", 32'(la & model[2][0]), 32'(csr_txen));
      check_val("csr_rxen", 32'(la & model[3][0]), 32'(csr_rxen));
      wb_read(0, reg_status, d);
      check_val("m0_rsp.dat status", la ? 32'h10 : 32'h0, d);   // bit 4
   endtask

   task automatic test_link();
      begin_test("link qualification");
      wb_write(0, reg_txmode, 32'h0003_0001);          // tx on, credits off
      model[2] = 32'h0003_0001;
      wb_write(0, reg_rxmode, 32'h0001_0000);          // rx off
      model[3] = 32'h0001_0000;
      @(posedge clk);
      devicemode     <= 1'b1;
      deviceready    <= 1'b0;
      phy_linkactive <= 1'b1;
      settle(3);
      check_link(1'b0);                                // device not ready
      @(posedge clk);
      deviceready <= 1'b1;
      settle(2);
      check_link(1'b1);
      @(posedge clk);
      devicemode  <= 1'b0;                             // host mode
      deviceready <= 1'b0;
      settle(2);
      check_link(1'b1);
      @(posedge clk);
      phy_linkactive <= 1'b0;
      settle(2);
      check_link(1'b0);
      @(posedge clk);
      phy_linkactive <= 1'b1;
      settle(2);
      check_link(1'b1);
      wb_write(0, reg_txmode, 32'h0003_0000);          // tx off
      model[2] = 32'h0003_0000;
      wb_write(0, reg_rxmode, 32'h0001_0001);          // rx on
      model[3] = 32'h0001_0001;
      settle(0);
      check_link(1'b1);
      model[1] = 32'h10;
      end_test();
   endtask

   task automatic test_arbitration();
      localparam int rounds = 8;
      reg_data_t d0;
      reg_data_t d1;
      int        w0;
      int        w1;
      int        base0;
      int        base1;
      int        solo;
      begin_test("arbitration");
      ack_order.delete();
      settle(0);
      base0 = ack_cnt0;
      base1 = ack_cnt1;
      for (int i = 0; i < rounds; i++) begin
         solo = i % 2;                                 // served last before the tie
         w0   = rw_word(int'(rand_word() % 32'd5));
         wb_read(solo, adr_of(w0), d0);
         check_val($sformatf("m%0d_rsp.dat @%02h", solo, adr_of(w0)), model[w0], d0);
         w0 = rw_word(int'(rand_word() % 32'd5));
         w1 = rw_word(int'(rand_word() % 32'd5));
         fork                                          // same start cycle
            wb_read(0, adr_of(w0), d0);
            wb_read(1, adr_of(w1), d1);
         join
         check_val($sformatf("m0_rsp.dat @%02h", adr_of(w0)), model[w0], d0);
         check_val($sformatf("m1_rsp.dat @%02h", adr_of(w1)), model[w1], d1);
      end
      settle(1);
      check_val("m0 ack count", 32'(rounds + rounds / 2), 32'(ack_cnt0 - base0));
      check_val("m1 ack count", 32'(rounds + rounds / 2), 32'(ack_cnt1 - base1));
      for (int i = 1; i < ack_order.size(); i++) begin
         assert (ack_order[i] != ack_order[i-1])
            else begin
               $display("ack %0d went to m%0d twice in a row", i, ack_order[i]);
               errors++;
            end
      end
      end_test();
   endtask

   task automatic check_update_period(input int period, input int pulses);
      int last;
      int seen;
      last = -1;
      seen = 0;
      while (seen < pulses) begin
         @(negedge clk);
         if (crdt_update) begin
            if (last >= 0)
               check_val("crdt_update period", 32'(period), 32'(cycle - last));
            last = cycle;
            seen++;
         end
      end
   endtask

   task automatic run_traffic(input int n);
      logic [31:0] r;
      repeat (n) begin
         r = rand_word();
         @(posedge clk);
         tx_pkt_req   <= (r[1:0] != 2'b00);             // req drains toward 0
         rx_crdt_req  <= r[2] & r[3];
         tx_pkt_resp  <= r[4] & r[5];                   // resp fills toward max
         rx_crdt_resp <= (r[7:6] != 2'b00);
         req_model  = sat_step(req_model, r[1:0] != 2'b00, r[2] & r[3]);
         resp_model = sat_step(resp_model, r[4] & r[5], r[7:6] != 2'b00);
      end
      @(posedge clk);
      tx_pkt_req   <= 1'b0;
      rx_crdt_req  <= 1'b0;
      tx_pkt_resp  <= 1'b0;
      rx_crdt_resp <= 1'b0;
   endtask

   task automatic test_credits();
      reg_data_t d;
      crdt_t     init_req;
      crdt_t     init_resp;
      begin_test("credit tracking");
      d         = rand_word();
      init_req  = {13'h0000, d[2:0]};
      init_resp = 16'hfffc;
      wb_write(0, reg_crdtinit, {init_resp, init_req});
      model[4] = {init_resp, init_req};
      wb_write(0, reg_crdtintrvl, 32'd7);
      model[5] = 32'd7;
      wb_read(0, reg_crdtstat, d);
      check_val("crdtstat disabled", {init_resp, init_req}, d);
      repeat (16) begin                                // two periods, timer stopped
         @(negedge clk);
         check_val("crdt_update", 32'h0, 32'(crdt_update));
      end
      model[2] = model[2] | 32'h10;                    // credit update enable
      wb_write(0, reg_txmode, model[2]);
      wb_read(0, reg_crdtstat, d);
      check_val("crdtstat loaded", {init_resp, init_req}, d);
      check_update_period(8, 4);
      req_model  = init_req;
      resp_model = init_resp;
      run_traffic(60);
      wb_read(0, reg_crdtstat, d);
      check_val("crdtstat", {resp_model, req_model}, d);
      run_traffic(60);
      wb_read(0, reg_crdtstat, d);
      check_val("crdtstat", {resp_model, req_model}, d);
      model[2] = model[2] & ~32'h10;
      wb_write(0, reg_txmode, model[2]);
      wb_read(0, reg_crdtstat, d);
      check_val("crdtstat reloaded", {init_resp, init_req}, d);
      end_test();
   endtask

   //########################################################################
   // main sequence
   //########################################################################
   initial begin
      nreset         = 1'b0;
      m0_req         = '0;
      m1_req         = '0;
      devicemode     = 1'b0;
      deviceready    = 1'b0;
      phy_linkactive = 1'b0;
      tx_pkt_req     = 1'b0;
      tx_pkt_resp    = 1'b0;
      rx_crdt_req    = 1'b0;
      rx_crdt_resp   = 1'b0;
      seed           = 32'hf2a6;
      repeat (8) @(posedge clk);
      nreset <= 1'b1;
      settle(1);
      test_reset();
      test_readback();
      test_link();
      test_arbitration();
      test_credits();
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- tb_clkgen.sv
//##########################################################################
// testbench clock generator, 10 ns period
//##########################################################################
`timescale 1ns/100ps

module tb_clkgen (
   output logic clk
);
   localparam time half_period = 5ns;

   initial clk = 1'b0;

   always #(half_period) clk = ~clk;   // free running

endmodule

//--- link_ctrl_top.sv
//##########################################################################
// link control top with arbiter, register block and credit tracker
//##########################################################################
`timescale 1ns/100ps

module link_ctrl_top (
   input  logic               clk,
   input  logic               nreset,
   // register bus masters
   input  link_pkg::wb_req_t  m0_req,            // host config
   input  link_pkg::wb_req_t  m1_req,            // local mgmt
   output link_pkg::wb_rsp_t  m0_rsp,
   output link_pkg::wb_rsp_t  m1_rsp,
   // link state
   input  logic               devicemode,
   input  logic               deviceready,
   input  logic               phy_linkactive,
   // traffic events
   input  logic               tx_pkt_req,
   input  logic               tx_pkt_resp,
   input  logic               rx_crdt_req,
   input  logic               rx_crdt_resp,
   // link controls
   output logic               host_linkactive,
   output logic [1:0]         csr_arbmode,
   output logic               csr_txen,
   output logic               csr_rxen,
   output link_pkg::iowidth_t csr_txiowidth,
   output link_pkg::iowidth_t csr_rxiowidth,
   output logic               crdt_update
);
   import link_pkg::*;

   wb_req_t   s_req;            // arbitrated request
   wb_rsp_t   s_rsp;
   logic      txcrdt_en;
   crdt_t     crdt_init_req;
   crdt_t     crdt_init_resp;
   crdt_t     crdt_intrvl;
   reg_data_t crdt_status;

   wb_arbiter u_wb_arbiter (
      .clk    (clk),
      .nreset (nreset),
      .m0_req (m0_req),
      .m1_req (m1_req),
      .m0_rsp (m0_rsp),
      .m1_rsp (m1_rsp),
      .s_req  (s_req),
      .s_rsp  (s_rsp)
   );

   link_regs u_link_regs (
      .clk             (clk),
      .nreset          (nreset),
      .s_req           (s_req),
      .s_rsp           (s_rsp),
      .devicemode      (devicemode),
      .deviceready     (deviceready),
      .phy_linkactive  (phy_linkactive),
      .crdt_status     (crdt_status),
      .host_linkactive (host_linkactive),
      .csr_arbmode     (csr_arbmode),
      .csr_txen        (csr_txen),
      .csr_rxen        (csr_rxen),
      .csr_txiowidth   (csr_txiowidth),
      .csr_rxiowidth   (csr_rxiowidth),
      .txcrdt_en       (txcrdt_en),
      .crdt_init_req   (crdt_init_req),
      .crdt_init_resp  (crdt_init_resp),
      .crdt_intrvl     (crdt_intrvl)
   );

   tx_credit_tracker u_tx_credit_tracker (
      .clk            (clk),
      .nreset         (nreset),
      .txcrdt_en      (txcrdt_en),
      .crdt_init_req  (crdt_init_req),
      .crdt_init_resp (crdt_init_resp),
      .crdt_intrvl    (crdt_intrvl),
      .tx_pkt_req     (tx_pkt_req),
      .tx_pkt_resp    (tx_pkt_resp),
      .rx_crdt_req    (rx_crdt_req),
      .rx_crdt_resp   (rx_crdt_resp),
      .crdt_status    (crdt_status),
      .crdt_update    (crdt_update)
   );

endmodule

//--- tx_credit_tracker.sv
//##########################################################################
// request and response credit counters, credit update interval timer
//##########################################################################
`timescale 1ns/100ps

module tx_credit_tracker (
   input  logic                clk,
   input  logic                nreset,
   input  logic                txcrdt_en,
   input  link_pkg::crdt_t     crdt_init_req,
   input  link_pkg::crdt_t     crdt_init_resp,
   input  link_pkg::crdt_t     crdt_intrvl,
   input  logic                tx_pkt_req,     // packet sent, uses a credit
   input  logic                tx_pkt_resp,
   input  logic                rx_crdt_req,    // one credit back
   input  logic                rx_crdt_resp,
   output link_pkg::reg_data_t crdt_status,
   output logic                crdt_update     // one cycle pulse
);
   import link_pkg::*;

   crdt_t req_cnt;
   crdt_t resp_cnt;
   crdt_t intrvl_cnt;

   // saturating step, send and return together cancel
   function automatic crdt_t crdt_next(crdt_t cnt, logic sent, logic back);
      crdt_t nxt;
      nxt = cnt;
      if (sent && !back && cnt != 16'h0000)
         nxt = cnt - 16'd1;
      else if (back && !sent && cnt != 16'hffff)
         nxt = cnt + 16'd1;
      return nxt;
   endfunction

   //########################################################################
   // credit counters
   //########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         req_cnt  <= '0;
         resp_cnt <= '0;
      end else if (!txcrdt_en) begin
         req_cnt  <= crdt_init_req;     // track init while disabled
         resp_cnt <= crdt_init_resp;
      end else begin
         req_cnt  <= crdt_next(req_cnt, tx_pkt_req, rx_crdt_req);
         resp_cnt <= crdt_next(resp_cnt, tx_pkt_resp, rx_crdt_resp);
      end
   end

   assign crdt_status = {resp_cnt, req_cnt};

   //########################################################################
   // update interval, period crdt_intrvl+1
   //########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         intrvl_cnt  <= '0;
         crdt_update <= 1'b0;
      end else if (!txcrdt_en) begin
         intrvl_cnt  <= '0;             // held at zero
         crdt_update <= 1'b0;
      end else if (intrvl_cnt == crdt_intrvl) begin
         intrvl_cnt  <= '0;             // wrap and fire
         crdt_update <= 1'b1;
      end else begin
         intrvl_cnt  <= intrvl_cnt + 16'd1;
         crdt_update <= 1'b0;
      end
   end

endmodule

//--- link_regs.sv
//##########################################################################
// link config and status registers, linkactive qualification,
// write decode, registered read mux and wishbone slave ack
//##########################################################################
`timescale 1ns/100ps

module link_regs (
   input  logic                clk,
   input  logic                nreset,
   // register bus
   input  link_pkg::wb_req_t   s_req,
   output link_pkg::wb_rsp_t   s_rsp,
   // link state
   input  logic                devicemode,      // 1 = device side
   input  logic                deviceready,
   input  logic                phy_linkactive,
   input  link_pkg::reg_data_t crdt_status,     // resp count in upper half
   // link controls
   output logic                host_linkactive,
   output logic [1:0]          csr_arbmode,
   output logic                csr_txen,
   output logic                csr_rxen,
   output link_pkg::iowidth_t  csr_txiowidth,
   output link_pkg::iowidth_t  csr_rxiowidth,
   // credit tracker config
   output logic                txcrdt_en,
   output link_pkg::crdt_t     crdt_init_req,
   output link_pkg::crdt_t     crdt_init_resp,
   output link_pkg::crdt_t     crdt_intrvl
);
   import link_pkg::*;

   reg_data_t  ctrl_reg;
   reg_data_t  status_reg;
   reg_data_t  txmode_reg;
   reg_data_t  rxmode_reg;
   reg_data_t  crdtinit_reg;
   crdt_t      crdtintrvl_reg;
   logic       linkactive;

   logic       ack_q;
   reg_data_t  rd_dat;
   logic       acc;                              // access on the acking edge
   logic       wr;
   logic [5:0] word;                             // word select

   //########################################################################
   // bus side
   //########################################################################
   assign acc  = s_req.cyc & s_req.stb & ~ack_q; // one ack per strobe
   assign wr   = acc & s_req.we;
   assign word = s_req.adr[7:2];

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         ack_q <= 1'b0;
      else
         ack_q <= acc;                           // single cycle pulse
   end

   assign s_rsp.ack = ack_q;
   assign s_rsp.dat = rd_dat;

   //########################################################################
   // linkactive and status
   //########################################################################
   // device side waits for deviceready, host side follows the phy
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         linkactive <= 1'b0;
      else if (!devicemode || deviceready)
         linkactive <= phy_linkactive;
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         status_reg <= '0;
      else
         status_reg <= {27'h0, linkactive, 4'h0};   // linkactive on bit 4
   end

   //########################################################################
   // config registers, written on the acking edge
   //########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ctrl_reg       <= '0;
         txmode_reg     <= mode_reset;
         rxmode_reg     <= mode_reset;
         crdtinit_reg   <= {crdt_depth, crdt_depth};
         crdtintrvl_reg <= intrvl_reset;
      end else if (wr) begin
         // status, crdtstat and holes fall through untouched
         if (word == reg_ctrl[7:2])
            ctrl_reg <= s_req.dat;
         if (word == reg_txmode[7:2])
            txmode_reg <= s_req.dat;
         if (word == reg_rxmode[7:2])
            rxmode_reg <= s_req.dat;
         if (word == reg_crdtinit[7:2])
            crdtinit_reg <= s_req.dat;
         if (word == reg_crdtintrvl[7:2])
            crdtintrvl_reg <= s_req.dat[15:0];   // low half only
      end
   end

   // read data lands with ack
   always_ff @(posedge clk) begin
      if (acc && !s_req.we) begin
         case (word)
            reg_ctrl[7:2]       : rd_dat <= ctrl_reg;
            reg_status[7:2]     : rd_dat <= status_reg;
            reg_txmode[7:2]     : rd_dat <= txmode_reg;
            reg_rxmode[7:2]     : rd_dat <= rxmode_reg;
            reg_crdtinit[7:2]   : rd_dat <= crdtinit_reg;
            reg_crdtintrvl[7:2] : rd_dat <= {16'h0000, crdtintrvl_reg};
            reg_crdtstat[7:2]   : rd_dat <= crdt_status;
            default             : rd_dat <= '0;   // unmapped
         endcase
      end
   end

   //########################################################################
   // control outputs
   //########################################################################
   assign host_linkactive = linkactive;
   assign csr_arbmode     = ctrl_reg[5:4];
   assign csr_txen        = linkactive & txmode_reg[0];
   assign csr_rxen        = linkactive & rxmode_reg[0];
   assign csr_txiowidth   = txmode_reg[23:16];
   assign csr_rxiowidth   = rxmode_reg[23:16];

   assign txcrdt_en       = txmode_reg[4];        // credit update enable
   assign crdt_init_req   = crdtinit_reg[15:0];
   assign crdt_init_resp  = crdtinit_reg[31:16];
   assign crdt_intrvl     = crdtintrvl_reg;

endmodule

//--- wb_arbiter.sv
//##########################################################################
// two master wishbone classic arbiter, round robin, grant held per cycle
//##########################################################################
`timescale 1ns/100ps

module wb_arbiter (
   input  logic              clk,
   input  logic              nreset,
   input  link_pkg::wb_req_t m0_req,    // host config port
   input  link_pkg::wb_req_t m1_req,    // local mgmt port
   output link_pkg::wb_rsp_t m0_rsp,
   output link_pkg::wb_rsp_t m1_rsp,
   output link_pkg::wb_req_t s_req,     // to register slave
   input  link_pkg::wb_rsp_t s_rsp
);
   import link_pkg::*;

   typedef enum logic [1:0] {idle, gnt0, gnt1} arb_state_t;

   arb_state_t state;
   arb_state_t state_nxt;
   logic       last_m1;                 // m1 was served most recently

   // re-arbitrate only when idle or when the owner has dropped cyc
   always_comb begin
      state_nxt = state;
      if (state == idle ||
          (state == gnt0 && !m0_req.cyc) ||
          (state == gnt1 && !m1_req.cyc)) begin
         if (m0_req.cyc && m1_req.cyc)
            state_nxt = last_m1 ? gnt0 : gnt1;   // other one wins the tie
         else if (m0_req.cyc)
            state_nxt = gnt0;
         else if (m1_req.cyc)
            state_nxt = gnt1;
         else
            state_nxt = idle;
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state   <= idle;
         last_m1 <= 1'b1;               // m0 takes the first tie
      end else begin
         state <= state_nxt;
         if (state_nxt == gnt0)
            last_m1 <= 1'b0;
         else if (state_nxt == gnt1)
            last_m1 <= 1'b1;
      end
   end

   // request mux, bus cycle masked while nobody owns it
   always_comb begin
      s_req = (state == gnt1) ? m1_req : m0_req;
      if (state == idle)
         s_req.cyc = 1'b0;
   end

   // data goes to both, ack only to the owner
   always_comb begin
      m0_rsp     = s_rsp;
      m0_rsp.ack = s_rsp.ack & (state == gnt0);
      m1_rsp     = s_rsp;
      m1_rsp.ack = s_rsp.ack & (state == gnt1);
   end

endmodule

//--- link_pkg.sv
//##########################################################################
// package with register bus types, register map offsets, reset values
// and the wishbone request and response structs
//##########################################################################
package link_pkg;

   //########################################################################
   // widths that carry a meaning
   //########################################################################
   typedef logic [7:0]  reg_addr_t;   // byte address, word select on 7..2
   typedef logic [31:0] reg_data_t;   // register word
   typedef logic [15:0] crdt_t;       // credit count or interval
   typedef logic [7:0]  iowidth_t;    // pad width is 2**code bytes

   // wishbone classic request, driven by a master
   typedef struct packed {
      logic      cyc;
      logic      stb;
      logic      we;
      reg_addr_t adr;
      reg_data_t dat;   // write data, always a full word
   } wb_req_t;

   // wishbone classic response, driven by the slave
   typedef struct packed {
      logic      ack;
      reg_data_t dat;   // read data
   } wb_rsp_t;

   //########################################################################
   // register map
   //########################################################################
   localparam reg_addr_t reg_ctrl       = 8'h00;   // arbitration mode
   localparam reg_addr_t reg_status     = 8'h04;   // read only
   localparam reg_addr_t reg_txmode     = 8'h08;
   localparam reg_addr_t reg_rxmode     = 8'h0c;
   localparam reg_addr_t reg_crdtinit   = 8'h10;   // resp in upper half
   localparam reg_addr_t reg_crdtintrvl = 8'h14;
   localparam reg_addr_t reg_crdtstat   = 8'h18;   // live counts, read only

   // reset values
   localparam iowidth_t init_iowidth = 8'd2;       // 4 byte pads
   localparam crdt_t    crdt_depth   = 16'd13;     // both credit halves
   localparam crdt_t    intrvl_reset = 16'h00ff;

   // mode word layout
   // bit 0 enable, bit 4 credit update enable (tx only), 23..16 pad width
   localparam reg_data_t mode_reset = {8'h00, init_iowidth, 15'h0000, 1'b1};

endpackage
